// ==== logic/matmul_settings.svh ====
// Fixed-point format, array size and matrix dimensions
// Shared by the package and the RTL modules
`ifndef MATMUL_SETTINGS_SVH
`define MATMUL_SETTINGS_SVH

`define DATA_W    16 // Operand and output element
`define FRAC_W    8  // Q8.8 operands
`define ACC_W     32
`define BLOCK     2  // Array is BLOCK x BLOCK
`define INNER     4  // Shared dimension K, at least 2*BLOCK

// Matrix C is A_ROWS x B_COLS
`define A_ROWS    4
`define B_COLS    4
`define TILE_ROWS (`A_ROWS / `BLOCK)
`define TILE_COLS (`B_COLS / `BLOCK)

`define ADDR_W    4  // 16 words per operand RAM

`endif

// ==== logic/matmul_pkg.sv ====
// Operand, accumulator, RAM word and output row types
// Controller state encoding
`include "matmul_settings.svh"

package matmul_pkg;

    typedef logic signed [`DATA_W-1:0] operand_t;
    typedef logic signed [`ACC_W-1:0]  acc_t;

    // One lane per array row or column
    typedef operand_t [`BLOCK-1:0] mem_word_t;
    typedef operand_t [`BLOCK-1:0] out_row_t;

    // Sized for the larger tile count
    localparam int TILE_W = $clog2(((`TILE_ROWS > `TILE_COLS) ? `TILE_ROWS : `TILE_COLS) + 1);
    typedef logic [TILE_W-1:0] tile_idx_t;

    typedef enum logic [1:0] {
        IDLE,
        STREAM, // Operand words leaving the RAMs
        FLUSH   // Last tiles still in the array or drain
    } ctrl_state_t;

endpackage

// ==== logic/tile_ram.sv ====
// Inferred single-clock operand RAM
// One write port, one read port with registered output
`include "matmul_settings.svh"

module tile_ram (
    input  logic                  clk,
    input  logic                  we,
    input  logic [`ADDR_W-1:0]    waddr,
    input  matmul_pkg::mem_word_t wdata,
    input  logic                  re,
    input  logic [`ADDR_W-1:0]    raddr,
    output matmul_pkg::mem_word_t rdata
);
    import matmul_pkg::*;

    mem_word_t mem [2**`ADDR_W];

    // Host side
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[raddr]; // Data one cycle after re
        end
    end

endmodule

// ==== logic/mac_cell.sv ====
// Output-stationary processing element
// Fixed-point multiply-accumulate, operand and flag forwarding
`include "matmul_settings.svh"

module mac_cell (
    input  logic                 clk,
    input  logic                 rst_n,
    input  matmul_pkg::operand_t a_in,
    input  matmul_pkg::operand_t b_in,
    input  logic                 first_in,
    input  logic                 last_in,
    input  logic                 valid_in,
    output matmul_pkg::operand_t a_out,
    output matmul_pkg::operand_t b_out,
    output logic                 first_out,
    output logic                 last_out,
    output logic                 valid_out,
    output matmul_pkg::acc_t     result
);
    import matmul_pkg::*;

    logic signed [2*`DATA_W-1:0] product; // Full signed product
    acc_t                        term;
    acc_t                        acc;
    acc_t                        acc_next;

    always_comb begin
        product  = a_in * b_in;
        term     = acc_t'(product >>> `FRAC_W); // Truncate to FRAC_W fraction bits
        acc_next = first_in ? term : acc + term; // first starts a new sum
    end

    always_ff @(posedge clk) begin
        a_out <= a_in; // To the right
        b_out <= b_in; // Downwards
        if (valid_in) begin
            acc <= acc_next;
            if (last_in) begin
                result <= acc_next; // Held until the next tile's last
            end
        end
    end

    // Flags travel right with a
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            first_out <= 1'b0;
            last_out  <= 1'b0;
            valid_out <= 1'b0;
        end else begin
            first_out <= first_in;
            last_out  <= last_in & valid_in;
            valid_out <= valid_in;
        end
    end

    // Skew and neighbour flags stay clean out of reset
    valid_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(valid_in));

endmodule

// ==== logic/systolic_array.sv ====
// BLOCK x BLOCK grid of MAC cells
// Row and column skew registers, tile-done flag from the last cell
`include "matmul_settings.svh"

module systolic_array (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  matmul_pkg::mem_word_t                     a_col, // Lane i feeds row i
    input  matmul_pkg::mem_word_t                     b_row, // Lane j feeds column j
    input  logic                                      valid, // Read strobe, data follows
    input  logic                                      first_k,
    input  logic                                      last_k,
    output logic                                      tile_done,
    output matmul_pkg::acc_t [`BLOCK-1:0][`BLOCK-1:0] results
);
    import matmul_pkg::*;

    logic     data_valid; // valid lined up with RAM data
    // Grid wiring, index BLOCK is the far edge
    operand_t a_h     [`BLOCK][`BLOCK+1];
    logic     first_h [`BLOCK][`BLOCK+1];
    logic     last_h  [`BLOCK][`BLOCK+1];
    logic     valid_h [`BLOCK][`BLOCK+1];
    operand_t b_v     [`BLOCK+1][`BLOCK];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_valid <= 1'b0;
        end else begin
            data_valid <= valid;
        end
    end

    // Row i starts i cycles late, flags ride with a
    for (genvar i = 0; i < `BLOCK; i++) begin : g_row_skew
        if (i == 0) begin : g_direct
            assign a_h[0][0] = a_col[0];
            assign {first_h[0][0], last_h[0][0], valid_h[0][0]} = {first_k, last_k, data_valid};
        end else begin : g_delay
            operand_t   a_d    [i];
            logic [2:0] flag_d [i]; // first, last, valid

            always_ff @(posedge clk) begin
                a_d[0] <= a_col[i];
                for (int s = 1; s < i; s++) begin
                    a_d[s] <= a_d[s-1];
                end
            end

            always_ff @(posedge clk) begin
                if (!rst_n) begin
                    flag_d <= '{default: '0};
                end else begin
                    flag_d[0] <= {first_k, last_k, data_valid};
                    for (int s = 1; s < i; s++) begin
                        flag_d[s] <= flag_d[s-1];
                    end
                end
            end

            assign a_h[i][0] = a_d[i-1];
            assign {first_h[i][0], last_h[i][0], valid_h[i][0]} = flag_d[i-1];
        end
    end

    // Column j starts j cycles late
    for (genvar j = 0; j < `BLOCK; j++) begin : g_col_skew
        if (j == 0) begin : g_direct
            assign b_v[0][0] = b_row[0];
        end else begin : g_delay
            operand_t b_d [j];

            always_ff @(posedge clk) begin
                b_d[0] <= b_row[j];
                for (int s = 1; s < j; s++) begin
                    b_d[s] <= b_d[s-1];
                end
            end

            assign b_v[0][j] = b_d[j-1];
        end
    end

    // Cell (i,j) sees operand k at k+i+j
    for (genvar i = 0; i < `BLOCK; i++) begin : g_r
        for (genvar j = 0; j < `BLOCK; j++) begin : g_c
            mac_cell u_cell (
                .clk       (clk),
                .rst_n     (rst_n),
                .a_in      (a_h[i][j]),
                .b_in      (b_v[i][j]),
                .first_in  (first_h[i][j]),
                .last_in   (last_h[i][j]),
                .valid_in  (valid_h[i][j]),
                .a_out     (a_h[i][j+1]),
                .b_out     (b_v[i+1][j]),
                .first_out (first_h[i][j+1]),
                .last_out  (last_h[i][j+1]),
                .valid_out (valid_h[i][j+1]),
                .result    (results[i][j])
            );
        end
    end

    assign tile_done = last_h[`BLOCK-1][`BLOCK]; // Last cell holds its sum, all results ready

endmodule

// ==== logic/tile_drain.sv ====
// Tile result capture and saturation to DATA_W
// Emits one row per cycle with its tile coordinates
`include "matmul_settings.svh"

module tile_drain (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      tile_done,
    input  matmul_pkg::acc_t [`BLOCK-1:0][`BLOCK-1:0] results,
    input  matmul_pkg::tile_idx_t                     tile_row,
    input  matmul_pkg::tile_idx_t                     tile_col,
    output logic                                      out_valid,
    output matmul_pkg::out_row_t                      out_data,
    output matmul_pkg::tile_idx_t                     out_tile_row,
    output matmul_pkg::tile_idx_t                     out_tile_col
);
    import matmul_pkg::*;

    localparam int   ROW_W   = (`BLOCK > 1) ? $clog2(`BLOCK) : 1;
    localparam acc_t SAT_MAX = acc_t'((1 << (`DATA_W - 1)) - 1);
    localparam acc_t SAT_MIN = -SAT_MAX - acc_t'(1);

    out_row_t         held [`BLOCK]; // Saturated tile
    logic [ROW_W-1:0] row_idx;       // Row on out_data
    logic             last_row;

    function automatic operand_t saturate(acc_t v);
        if (v > SAT_MAX) begin
            return operand_t'(SAT_MAX);
        end else if (v < SAT_MIN) begin
            return operand_t'(SAT_MIN);
        end
        return operand_t'(v);
    endfunction

    assign last_row = row_idx == ROW_W'(`BLOCK - 1);
    assign out_data = held[row_idx];

    always_ff @(posedge clk) begin
        if (tile_done) begin
            for (int r = 0; r < `BLOCK; r++) begin
                for (int c = 0; c < `BLOCK; c++) begin
                    held[r][c] <= saturate(results[r][c]);
                end
            end
            out_tile_row <= tile_row;
            out_tile_col <= tile_col;
        end
    end

    // Row sequencer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            row_idx   <= '0;
        end else if (tile_done) begin
            out_valid <= 1'b1;
            row_idx   <= '0;
        end else if (out_valid) begin
            if (last_row) begin
                out_valid <= 1'b0;
            end else begin
                row_idx <= row_idx + 1'b1;
            end
        end
    end

    // Tiles spaced INNER apart, a new one may only land on the final row
    drain_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        tile_done |-> !out_valid || last_row);

endmodule

// ==== logic/matmul_controller.sv ====
// Operand streaming FSM with k, column and row tile counters
// Tile coordinate FIFO matching the array latency, busy and done
`include "matmul_settings.svh"

module matmul_controller (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  logic                  tile_done,
    output logic                  rd_en,
    output logic                  first_k,
    output logic                  last_k,
    output logic [`ADDR_W-1:0]    in_rd_addr,
    output logic [`ADDR_W-1:0]    wt_rd_addr,
    output matmul_pkg::tile_idx_t tile_row,
    output matmul_pkg::tile_idx_t tile_col,
    output logic                  busy,
    output logic                  done
);
    import matmul_pkg::*;

    localparam int K_W     = $clog2(`INNER);
    localparam int N_TILES = `TILE_ROWS * `TILE_COLS;
    localparam int CNT_W   = $clog2(N_TILES + 1);
    localparam int DRN_W   = $clog2(`BLOCK + 1);

    ctrl_state_t      state;
    logic [K_W-1:0]   k_cnt;
    tile_idx_t        row_t;
    tile_idx_t        col_t;
    logic [CNT_W-1:0] tiles_seen; // tile_done pulses this run
    logic [DRN_W-1:0] drain_cnt;  // Rows of the final tile already out
    logic             k_last;
    logic             col_last;
    logic             row_last;
    tile_idx_t        fifo_row [2]; // Coordinates of tiles in the array
    tile_idx_t        fifo_col [2];
    logic             wr_ptr;
    logic             rd_ptr;

    assign rd_en      = state == STREAM; // One word per RAM per cycle
    assign k_last     = k_cnt == K_W'(`INNER - 1);
    assign col_last   = col_t == tile_idx_t'(`TILE_COLS - 1);
    assign row_last   = row_t == tile_idx_t'(`TILE_ROWS - 1);
    assign in_rd_addr = `ADDR_W'(int'(row_t) * `INNER + int'(k_cnt));
    assign wt_rd_addr = `ADDR_W'(int'(col_t) * `INNER + int'(k_cnt));
    assign tile_row   = fifo_row[rd_ptr]; // Head lines up with tile_done
    assign tile_col   = fifo_col[rd_ptr];

    // Push on a tile's last read
    always_ff @(posedge clk) begin
        if (rd_en && k_last) begin
            fifo_row[wr_ptr] <= row_t;
            fifo_col[wr_ptr] <= col_t;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= IDLE;
            k_cnt      <= '0;
            row_t      <= '0;
            col_t      <= '0;
            tiles_seen <= '0;
            drain_cnt  <= '0;
            wr_ptr     <= 1'b0;
            rd_ptr     <= 1'b0;
            first_k    <= 1'b0;
            last_k     <= 1'b0;
            busy       <= 1'b0;
            done       <= 1'b0;
        end else begin
            first_k <= rd_en && k_cnt == '0; // Aligned with RAM read data
            last_k  <= rd_en && k_last;
            done    <= 1'b0;
            if (rd_en && k_last) begin
                wr_ptr <= ~wr_ptr;
            end
            if (tile_done) begin
                rd_ptr     <= ~rd_ptr;
                tiles_seen <= tiles_seen + 1'b1;
            end
            case (state)
                IDLE: begin
                    if (start) begin
                        state      <= STREAM;
                        busy       <= 1'b1;
                        k_cnt      <= '0;
                        row_t      <= '0;
                        col_t      <= '0;
                        tiles_seen <= '0;
                    end
                end
                STREAM: begin
                    k_cnt <= k_cnt + 1'b1;
                    if (k_last) begin // Next tile, row-major
                        k_cnt <= '0;
                        col_t <= col_last ? '0 : col_t + 1'b1;
                        if (col_last) begin
                            row_t <= row_t + 1'b1;
                            if (row_last) begin
                                state <= FLUSH;
                            end
                        end
                    end
                end
                FLUSH: begin
                    if (tile_done && tiles_seen == CNT_W'(N_TILES - 1)) begin
                        drain_cnt <= DRN_W'(1);
                    end else if (drain_cnt != '0) begin
                        if (drain_cnt == DRN_W'(`BLOCK)) begin // Last row just left
                            state     <= IDLE;
                            busy      <= 1'b0;
                            done      <= 1'b1;
                            drain_cnt <= '0;
                        end else begin
                            drain_cnt <= drain_cnt + 1'b1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    rd_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
        rd_en |-> int'(in_rd_addr) < `TILE_ROWS * `INNER &&
                  int'(wt_rd_addr) < `TILE_COLS * `INNER);

endmodule

// ==== logic/matmul_top.sv ====
// Matrix multiplier top level
// Operand RAMs, streaming controller, systolic array and drain
`include "matmul_settings.svh"

module matmul_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  logic                  in_we,   // Matrix A
    input  logic [`ADDR_W-1:0]    in_addr,
    input  matmul_pkg::mem_word_t in_data,
    input  logic                  wt_we,   // Matrix B
    input  logic [`ADDR_W-1:0]    wt_addr,
    input  matmul_pkg::mem_word_t wt_data,
    output logic                  busy,
    output logic                  done,
    output logic                  out_valid,
    output matmul_pkg::out_row_t  out_data,
    output matmul_pkg::tile_idx_t out_tile_row,
    output matmul_pkg::tile_idx_t out_tile_col
);
    import matmul_pkg::*;

    logic                          rd_en;
    logic                          first_k;
    logic                          last_k;
    logic                          tile_done;
    logic [`ADDR_W-1:0]            in_rd_addr;
    logic [`ADDR_W-1:0]            wt_rd_addr;
    mem_word_t                     in_rdata;
    mem_word_t                     wt_rdata;
    tile_idx_t                     tile_row;
    tile_idx_t                     tile_col;
    acc_t [`BLOCK-1:0][`BLOCK-1:0] results;

    tile_ram u_in_ram (
        .clk(clk), .we(in_we), .waddr(in_addr), .wdata(in_data),
        .re(rd_en), .raddr(in_rd_addr), .rdata(in_rdata)
    );

    tile_ram u_wt_ram (
        .clk(clk), .we(wt_we), .waddr(wt_addr), .wdata(wt_data),
        .re(rd_en), .raddr(wt_rd_addr), .rdata(wt_rdata)
    );

    matmul_controller u_ctrl (
        .clk(clk), .rst_n(rst_n), .start(start), .tile_done(tile_done),
        .rd_en(rd_en), .first_k(first_k), .last_k(last_k),
        .in_rd_addr(in_rd_addr), .wt_rd_addr(wt_rd_addr),
        .tile_row(tile_row), .tile_col(tile_col), .busy(busy), .done(done)
    );

    // A lanes run along rows, B lanes down columns
    systolic_array u_array (
        .clk(clk), .rst_n(rst_n), .a_col(in_rdata), .b_row(wt_rdata),
        .valid(rd_en), .first_k(first_k), .last_k(last_k),
        .tile_done(tile_done), .results(results)
    );

    tile_drain u_drain (
        .clk(clk), .rst_n(rst_n), .tile_done(tile_done), .results(results),
        .tile_row(tile_row), .tile_col(tile_col),
        .out_valid(out_valid), .out_data(out_data),
        .out_tile_row(out_tile_row), .out_tile_col(out_tile_col)
    );

endmodule

// ==== sim/matmul_tasks.svh ====
// Test helpers for the matrix multiplier testbench
// Operand fill and load, reference model, run and output collection
// Compare tasks for rows, tile coordinates, single bits and counts

task automatic report_failure(input string msg);
    $display("error at %0t: %s", $time, msg);
    error_count++;
endtask

task automatic compare_row(input out_row_t got, input out_row_t expected,
                           input tile_idx_t tr, input tile_idx_t tc, input int row);
    check_count++;
    for (int j = 0; j < `BLOCK; j++) begin
        if (got[j] !== expected[j]) begin
            $display("mismatch at %0t: tile (%0d,%0d) row %0d lane %0d got %0d expected %0d",
                     $time, tr, tc, row, j, got[j], expected[j]);
            error_count++;
        end
    end
endtask

task automatic compare_tile(input tile_idx_t got, input tile_idx_t expected, input string what);
    check_count++;
    if (got !== expected) begin
        $display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, expected);
        error_count++;
    end
endtask

task automatic compare_bit(input logic got, input logic expected, input string what);
    check_count++;
    if (got !== expected) begin
        $display("mismatch at %0t: %s got %b expected %b", $time, what, got, expected);
        error_count++;
    end
endtask

task automatic compare_count(input int got, input int expected, input string what);
    check_count++;
    if (got != expected) begin
        $display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, expected);
        error_count++;
    end
endtask

// Uniform values in [-span, span-1] for both operands
task automatic fill_random(input int span);
    for (int r = 0; r < `A_ROWS; r++) begin
        for (int k = 0; k < `INNER; k++) begin
            mat_a[r][k] = operand_t'(int'($urandom_range(2 * span - 1)) - span);
        end
    end
    for (int k = 0; k < `INNER; k++) begin
        for (int c = 0; c < `B_COLS; c++) begin
            mat_b[k][c] = operand_t'(int'($urandom_range(2 * span - 1)) - span);
        end
    end
endtask

// C from the fixed-point rule: truncated products, wide sum, saturate
task automatic build_expected();
    int   sat_hi;
    int   sat_lo;
    int   prod;
    acc_t sum;
    sat_hi = (1 << (`DATA_W - 1)) - 1;
    sat_lo = -(1 << (`DATA_W - 1));
    for (int r = 0; r < `A_ROWS; r++) begin
        for (int c = 0; c < `B_COLS; c++) begin
            sum = '0;
            for (int k = 0; k < `INNER; k++) begin
                prod = int'(mat_a[r][k]) * int'(mat_b[k][c]);
                sum += acc_t'(prod >>> `FRAC_W); // Drop fraction bits
            end
            if (int'(sum) > sat_hi) begin
                mat_c[r][c] = operand_t'(sat_hi);
            end else if (int'(sum) < sat_lo) begin
                mat_c[r][c] = operand_t'(sat_lo);
            end else begin
                mat_c[r][c] = operand_t'(sum);
            end
        end
    end
endtask

// One word per RAM per cycle, tile-major layout
task automatic load_operands();
    mem_word_t a_word;
    mem_word_t b_word;
    for (int t = 0; t < MAX_TILES; t++) begin
        for (int k = 0; k < `INNER; k++) begin
            a_word = '0;
            b_word = '0;
            for (int l = 0; l < `BLOCK; l++) begin
                if (t < `TILE_ROWS) begin
                    a_word[l] = mat_a[t * `BLOCK + l][k]; // Lane = row in tile
                end
                if (t < `TILE_COLS) begin
                    b_word[l] = mat_b[k][t * `BLOCK + l]; // Lane = column in tile
                end
            end
            @(posedge clk);
            in_we   <= t < `TILE_ROWS;
            wt_we   <= t < `TILE_COLS;
            in_addr <= `ADDR_W'(t * `INNER + k);
            wt_addr <= `ADDR_W'(t * `INNER + k);
            in_data <= a_word;
            wt_data <= b_word;
        end
    end
    @(posedge clk);
    in_we <= 1'b0;
    wt_we <= 1'b0;
endtask

task automatic pulse_start();
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
endtask

// Checks every row, the row-major tile order and the done spacing
task automatic collect_tiles(output int n_tiles);
    int        row_in_tile;
    int        last_row_cyc;
    int        done_cyc;
    out_row_t  expected_row;
    n_tiles      = 0;
    row_in_tile  = 0;
    last_row_cyc = -1;
    done_cyc     = -1;
    for (int cyc = 0; cyc < RUN_LIMIT && done_cyc < 0; cyc++) begin
        @(negedge clk); // Outputs settled
        if (out_valid) begin
            if (row_in_tile == 0) begin
                compare_tile(out_tile_row, tile_idx_t'(n_tiles / `TILE_COLS), "tile row");
                compare_tile(out_tile_col, tile_idx_t'(n_tiles % `TILE_COLS), "tile col");
            end
            if (out_tile_row < `TILE_ROWS && out_tile_col < `TILE_COLS) begin
                for (int j = 0; j < `BLOCK; j++) begin
                    expected_row[j] = mat_c[int'(out_tile_row) * `BLOCK + row_in_tile]
                                           [int'(out_tile_col) * `BLOCK + j];
                end
                compare_row(out_data, expected_row, out_tile_row, out_tile_col, row_in_tile);
            end else begin
                report_failure("output tile coordinates are out of range");
            end
            last_row_cyc = cyc;
            row_in_tile++;
            if (row_in_tile == `BLOCK) begin
                row_in_tile = 0;
                n_tiles++;
            end
        end else if (row_in_tile != 0) begin
            report_failure($sformatf("tile stopped after %0d rows", row_in_tile));
            row_in_tile = 0;
        end
        if (done) begin
            done_cyc = cyc;
            compare_bit(busy, 1'b0, "busy with done");
        end else begin
            compare_bit(busy, 1'b1, "busy before done"); // High for the whole run
        end
    end
    if (done_cyc < 0) begin
        report_failure($sformatf("done did not arrive within %0d cycles", RUN_LIMIT));
    end else begin
        compare_count(done_cyc - last_row_cyc, 1, "cycles from last row to done");
    end
endtask

// Nothing moves once done has been seen
task automatic check_quiet();
    int active;
    active = 0;
    repeat (QUIET_CYCLES) begin
        @(negedge clk);
        if (out_valid || busy || done) begin
            active++;
        end
    end
    compare_count(active, 0, "cycles with out_valid, busy or done after done");
endtask

// One full run, optionally with start pulses while busy
task automatic run_matmul(input bit extra_starts);
    int n_tiles;
    pulse_start();
    fork
        collect_tiles(n_tiles);
        begin
            if (extra_starts) begin
                repeat (2) begin
                    @(negedge clk);
                    compare_bit(busy, 1'b1, "busy before extra start");
                    @(posedge clk);
                    start <= 1'b1;
                    @(posedge clk);
                    start <= 1'b0;
                    repeat (4) @(posedge clk);
                end
            end
        end
    join
    compare_count(n_tiles, N_TILES, "tiles in run");
    check_quiet();
endtask

// ==== sim/matmul_tb.sv ====
// Testbench top for the fixed-point matrix multiplier
// Clock, reset, DUT instance, watchdog, directed tests and summary
`include "matmul_settings.svh"

module matmul_tb;
    import matmul_pkg::*;

    localparam int N_TESTS      = 5;
    localparam int N_TILES      = `TILE_ROWS * `TILE_COLS;
    localparam int MAX_TILES    = (`TILE_ROWS > `TILE_COLS) ? `TILE_ROWS : `TILE_COLS;
    localparam int TILE_CYCLES  = `INNER + 2 * `BLOCK + 4; // Stream, skew, drain, slack
    localparam int RUN_LIMIT    = N_TILES * TILE_CYCLES + 4 * `BLOCK;
    localparam int LOAD_CYCLES  = MAX_TILES * `INNER + 2;
    localparam int QUIET_CYCLES = 16;
    localparam int RESET_CYCLES = 5;
    // Test 5 runs twice, factor 3 covers it
    localparam int WATCHDOG_CYCLES =
        3 * N_TESTS * (N_TILES * TILE_CYCLES + LOAD_CYCLES + QUIET_CYCLES);

    logic               clk;
    logic               rst_n;
    logic               start;
    logic               in_we;
    logic [`ADDR_W-1:0] in_addr;
    mem_word_t          in_data;
    logic               wt_we;
    logic [`ADDR_W-1:0] wt_addr;
    mem_word_t          wt_data;
    logic               busy;
    logic               done;
    logic               out_valid;
    out_row_t           out_data;
    tile_idx_t          out_tile_row;
    tile_idx_t          out_tile_col;

    operand_t mat_a [`A_ROWS][`INNER];  // Input matrix
    operand_t mat_b [`INNER][`B_COLS];  // Weight matrix
    operand_t mat_c [`A_ROWS][`B_COLS]; // Expected result
    int       error_count;
    int       check_count;
    int       errors_mark; // error_count when the current test began
    int       test_num;
    int       tests_failed;

    `include "matmul_tasks.svh"

    matmul_top UUT (
        .clk(clk), .rst_n(rst_n), .start(start),
        .in_we(in_we), .in_addr(in_addr), .in_data(in_data),
        .wt_we(wt_we), .wt_addr(wt_addr), .wt_data(wt_data),
        .busy(busy), .done(done), .out_valid(out_valid), .out_data(out_data),
        .out_tile_row(out_tile_row), .out_tile_col(out_tile_col)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // Period 8
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, simulation stopped", WATCHDOG_CYCLES);
        $display("Test FAILED");
        $finish;
    end

    task automatic end_test(input string name);
        test_num++;
        if (error_count == errors_mark) begin
            $display("test %0d %s: passed", test_num, name);
        end else begin
            $display("test %0d %s: failed with %0d errors", test_num, name,
                     error_count - errors_mark);
            tests_failed++;
        end
        errors_mark = error_count;
    endtask

    // Identity weights, C is A itself
    task automatic test_identity();
        fill_random(1 << (`DATA_W - 1)); // Full range A
        for (int k = 0; k < `INNER; k++) begin
            for (int c = 0; c < `B_COLS; c++) begin
                mat_b[k][c] = (k == c) ? operand_t'(1 << `FRAC_W) : '0;
            end
        end
        for (int r = 0; r < `A_ROWS; r++) begin
            for (int c = 0; c < `B_COLS; c++) begin
                mat_c[r][c] = (c < `INNER) ? mat_a[r][c] : '0;
            end
        end
        load_operands();
        run_matmul(1'b0);
    endtask

    task automatic test_random_small();
        fill_random(512); // About +-2.0, no saturation
        build_expected();
        load_operands();
        run_matmul(1'b0);
    endtask

    // Even rows go to the top rail, odd rows to the bottom
    task automatic test_saturation();
        for (int r = 0; r < `A_ROWS; r++) begin
            for (int k = 0; k < `INNER; k++) begin
                mat_a[r][k] = operand_t'((r % 2 == 0) ? 16384 : -16384);
            end
        end
        for (int k = 0; k < `INNER; k++) begin
            for (int c = 0; c < `B_COLS; c++) begin
                mat_b[k][c] = operand_t'((c % 2 == 0) ? 16384 : 12288);
            end
        end
        build_expected();
        load_operands();
        run_matmul(1'b0);
    endtask

    task automatic test_start_while_busy();
        fill_random(512);
        build_expected();
        load_operands();
        run_matmul(1'b1);
    endtask

    task automatic test_reset_mid_run();
        fill_random(512);
        load_operands();
        pulse_start();
        for (int cyc = 0; cyc < RUN_LIMIT && !out_valid; cyc++) begin
            @(negedge clk);
        end
        if (!out_valid) begin
            report_failure("no output row appeared before the reset");
        end
        repeat (`INNER - 1) @(posedge clk); // Lands as the next tile's first row would
        rst_n <= 1'b0;
        @(posedge clk); // Reset seen here
        @(negedge clk);
        compare_bit(busy, 1'b0, "busy during reset");
        compare_bit(out_valid, 1'b0, "out_valid during reset");
        @(posedge clk);
        rst_n <= 1'b1;
        fill_random(512); // Fresh data for the second run
        build_expected();
        load_operands();
        run_matmul(1'b0);
    endtask

    initial begin
        rst_n        = 1'b0;
        start        = 1'b0;
        in_we        = 1'b0;
        in_addr      = '0;
        in_data      = '0;
        wt_we        = 1'b0;
        wt_addr      = '0;
        wt_data      = '0;
        error_count  = 0;
        check_count  = 0;
        errors_mark  = 0;
        test_num     = 0;
        tests_failed = 0;
        void'($urandom(32'hca1095cb));
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        test_identity();
        end_test("identity weights");
        test_random_small();
        end_test("random small operands");
        test_saturation();
        end_test("saturating products");
        test_start_while_busy();
        end_test("start while busy");
        test_reset_mid_run();
        end_test("reset mid-run");

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 test_num, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+logic
+incdir+sim
logic/matmul_pkg.sv
logic/tile_ram.sv
logic/mac_cell.sv
logic/systolic_array.sv
logic/tile_drain.sv
logic/matmul_controller.sv
logic/matmul_top.sv
sim/matmul_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the matrix multiplier testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --assert -Wno-fatal --top-module matmul_tb -Mdir "$BUILD_DIR" -f sources.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vmatmul_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# Pass only when the exact pass line is in the log
if grep -qx "Test OK" "$LOG"; then
    echo "Simulation passed"
    exit 0
fi

echo "Pass line not found in $LOG"
exit 1
